//--- src/ahb_periph_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared AHB-Lite bus widths, transfer and size codes, memory map
// and timer register offsets
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ahb_periph_pkg;

   //////////////////////////////////////////////////////////////////////
   // Bus widths
   //////////////////////////////////////////////////////////////////////

   localparam int HADDR_W = 32;                     // Address bus width
   localparam int HDATA_W = 32;                     // Data bus width

   // HTRANS codes, only NONSEQ and SEQ start a transfer
   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_BUSY   = 2'b01;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
   localparam logic [1:0] HTRANS_SEQ    = 2'b11;

   // HSIZE codes up to one bus word
   localparam logic [2:0] HSIZE_BYTE = 3'b000;
   localparam logic [2:0] HSIZE_HALF = 3'b001;
   localparam logic [2:0] HSIZE_WORD = 3'b010;

   //////////////////////////////////////////////////////////////////////
   // Memory map
   //////////////////////////////////////////////////////////////////////

   localparam logic [HADDR_W-1:0] SRAM_BASE  = 32'h0000_0000; // Lowest 512 MB
   localparam logic [HADDR_W-1:0] SRAM_MASK  = 32'hE000_0000;
   localparam logic [HADDR_W-1:0] TIMER_BASE = 32'h4000_0000; // 32 byte window
   localparam logic [HADDR_W-1:0] TIMER_MASK = 32'hFFFF_FFE0;

   // Address belongs to a slave when masked address equals its base
   function automatic logic addr_match(input logic [HADDR_W-1:0] addr,
                                       input logic [HADDR_W-1:0] base,
                                       input logic [HADDR_W-1:0] mask);
      return (addr & mask) == base;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Timer registers
   //////////////////////////////////////////////////////////////////////

   localparam int TMR_OFF_W = 5;                    // Byte offset inside the window

   localparam logic [TMR_OFF_W-1:0] TMR_CTRL     = 5'h00;
   localparam logic [TMR_OFF_W-1:0] TMR_PRESCALE = 5'h04; // Prescaler reload
   localparam logic [TMR_OFF_W-1:0] TMR_COUNT    = 5'h08;
   localparam logic [TMR_OFF_W-1:0] TMR_COMPARE  = 5'h0C;
   localparam logic [TMR_OFF_W-1:0] TMR_STATUS   = 5'h10; // Write one to clear

   // Bit positions
   localparam int TMR_CTRL_EN     = 0;              // Counter enable
   localparam int TMR_CTRL_IE     = 1;              // Interrupt enable
   localparam int TMR_STATUS_PEND = 0;              // Match pending

endpackage

`default_nettype wire

//--- src/ahb_decoder.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite address decoder with data-phase response steering
// and default slave ERROR responses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ahb_decoder
   import ahb_periph_pkg::*;
(
   input  wire                hclk_i,
   input  wire                rst_n_i,
   input  wire [HADDR_W-1:0]  haddr_i,
   input  wire [1:0]          htrans_i,
   output logic               hready_o,           // Shared bus ready
   output logic               hsel_sram_o,
   output logic               hsel_timer_o,
   input  wire [HDATA_W-1:0]  sram_hrdata_i,
   input  wire                sram_hreadyout_i,
   input  wire                sram_hresp_i,
   input  wire [HDATA_W-1:0]  timer_hrdata_i,
   input  wire                timer_hreadyout_i,
   input  wire                timer_hresp_i,
   output logic [HDATA_W-1:0] hrdata_o,
   output logic               hresp_o
);

   // Data phase owner
   localparam logic [1:0] DP_NONE  = 2'd0;        // Idle or unmapped
   localparam logic [1:0] DP_SRAM  = 2'd1;
   localparam logic [1:0] DP_TIMER = 2'd2;

   // Default slave error sequence
   localparam logic [1:0] ERR_IDLE   = 2'd0;
   localparam logic [1:0] ERR_FIRST  = 2'd1;      // hready low, hresp high
   localparam logic [1:0] ERR_SECOND = 2'd2;      // hready high, hresp high

   logic       active;
   logic       accept;
   logic       unmapped;
   logic [1:0] dp_slv_q;
   logic [1:0] err_q;

   //////////////////////////////////////////////////////////////////////
   // Address phase decode
   //////////////////////////////////////////////////////////////////////

   assign hsel_sram_o  = addr_match(haddr_i, SRAM_BASE, SRAM_MASK);
   assign hsel_timer_o = addr_match(haddr_i, TIMER_BASE, TIMER_MASK);
   assign unmapped     = !hsel_sram_o && !hsel_timer_o;
   assign active       = (htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ);
   assign accept       = active && hready_o;      // Address phase taken this edge

   // Owner of the next data phase, updated only when the bus moves on
   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dp_slv_q <= DP_NONE;
      end else if (hready_o) begin
         if (accept && hsel_sram_o)
            dp_slv_q <= DP_SRAM;
         else if (accept && hsel_timer_o)
            dp_slv_q <= DP_TIMER;
         else
            dp_slv_q <= DP_NONE;
      end
   end

   // Two cycle ERROR for unmapped transfers
   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= ERR_IDLE;
      end else begin
         case (err_q)
            ERR_FIRST: err_q <= ERR_SECOND;
            default:   err_q <= (accept && unmapped) ? ERR_FIRST : ERR_IDLE; // Back to back errors
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Data phase response mux
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (dp_slv_q)
         DP_SRAM: begin
            hready_o = sram_hreadyout_i;
            hresp_o  = sram_hresp_i;
            hrdata_o = sram_hrdata_i;
         end
         DP_TIMER: begin
            hready_o = timer_hreadyout_i;
            hresp_o  = timer_hresp_i;
            hrdata_o = timer_hrdata_i;
         end
         default: begin                          // Default slave
            hready_o = (err_q != ERR_FIRST);
            hresp_o  = (err_q != ERR_IDLE);
            hrdata_o = '0;
         end
      endcase
   end

   // At most one slave selected
   a_sel_onehot: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      !(hsel_sram_o && hsel_timer_o));

   // ERROR only from an unmapped acceptance or a slave owning the data phase
   a_resp_source: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      $rose(hresp_o) |-> $past(accept && unmapped) || (dp_slv_q != DP_NONE));

endmodule

`default_nettype wire

//--- src/ahb_sram.sv
//////////////////////////////////////////////////////////////////////
// Zero wait state AHB-Lite SRAM with byte lane writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ahb_sram
   import ahb_periph_pkg::*;
#(
   parameter int MEM_DEPTH = 512                  // Words, power of two
) (
   input  wire                hclk_i,
   input  wire                rst_n_i,
   input  wire                hsel_i,
   input  wire [HADDR_W-1:0]  haddr_i,
   input  wire [1:0]          htrans_i,
   input  wire                hwrite_i,
   input  wire [2:0]          hsize_i,
   input  wire [HDATA_W-1:0]  hwdata_i,
   input  wire                hready_i,
   output logic [HDATA_W-1:0] hrdata_o,
   output logic               hreadyout_o,
   output logic               hresp_o
);

   localparam int LANES = HDATA_W / 8;            // Byte lanes per word
   localparam int IDX_W = $clog2(MEM_DEPTH);

   logic [HDATA_W-1:0] mem [MEM_DEPTH];
   logic               accept;
   logic               dp_write_q;                // Write pending in data phase
   logic [IDX_W+1:0]   dp_addr_q;                 // Word index and byte offset
   logic [2:0]         dp_size_q;
   logic [IDX_W-1:0]   dp_idx;
   logic [LANES-1:0]   dp_be;

   assign accept = hsel_i && hready_i &&
                   ((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ));

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         dp_write_q <= 1'b0;
      else if (hready_i)
         dp_write_q <= accept && hwrite_i;
   end

   // Address phase capture
   always_ff @(posedge hclk_i) begin
      if (accept) begin
         dp_addr_q <= haddr_i[IDX_W+1:0];         // Upper bits alias
         dp_size_q <= hsize_i;
      end
   end

   assign dp_idx = dp_addr_q[IDX_W+1:2];

   // Little endian lane select
   always_comb begin
      case (dp_size_q)
         HSIZE_BYTE: dp_be = LANES'(1) << dp_addr_q[1:0];
         HSIZE_HALF: dp_be = LANES'(3) << {dp_addr_q[1], 1'b0};
         default:    dp_be = '1;
      endcase
   end

   // Write at end of data phase
   always_ff @(posedge hclk_i) begin
      if (dp_write_q && hready_i) begin
         for (int b = 0; b < LANES; b++) begin
            if (dp_be[b])
               mem[dp_idx][8*b +: 8] <= hwdata_i[8*b +: 8];
         end
      end
   end

   assign hrdata_o    = mem[dp_idx];              // Whole word on read
   assign hreadyout_o = 1'b1;
   assign hresp_o     = 1'b0;

   a_size_max: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      accept |-> (hsize_i <= HSIZE_WORD));

   // Halfwords and words naturally aligned
   a_aligned: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      accept |-> !((hsize_i == HSIZE_HALF) && haddr_i[0]) &&
                 !((hsize_i == HSIZE_WORD) && (haddr_i[1:0] != 2'b00)));

endmodule

`default_nettype wire

//--- src/ahb_timer.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite timer with prescaler, counter, compare match, status
// and registered interrupt
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ahb_timer
   import ahb_periph_pkg::*;
(
   input  wire                hclk_i,
   input  wire                rst_n_i,
   input  wire                hsel_i,
   input  wire [HADDR_W-1:0]  haddr_i,
   input  wire [1:0]          htrans_i,
   input  wire                hwrite_i,
   input  wire [2:0]          hsize_i,
   input  wire [HDATA_W-1:0]  hwdata_i,
   input  wire                hready_i,
   output logic [HDATA_W-1:0] hrdata_o,
   output logic               hreadyout_o,
   output logic               hresp_o,
   output logic               irq_o                // Registered interrupt
);

   logic                 accept;
   logic                 dp_write_q;
   logic [TMR_OFF_W-1:0] dp_off_q;                // Word aligned register offset
   logic                 wr_en;
   logic                 count_wr;
   logic [1:0]           ctrl_q;                  // IE and EN
   logic [HDATA_W-1:0]   prescale_q;
   logic [HDATA_W-1:0]   count_q;
   logic [HDATA_W-1:0]   compare_q;
   logic                 pending_q;
   logic [HDATA_W-1:0]   pre_cnt_q;               // Prescaler down counter
   logic                 tick;
   logic [HDATA_W-1:0]   count_inc;
   logic                 match_q;

   //////////////////////////////////////////////////////////////////////
   // Bus side
   //////////////////////////////////////////////////////////////////////

   assign accept = hsel_i && hready_i &&
                   ((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ));

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         dp_write_q <= 1'b0;
      else if (hready_i)
         dp_write_q <= accept && hwrite_i && (hsize_i == HSIZE_WORD); // Word writes only
   end

   always_ff @(posedge hclk_i) begin
      if (accept)
         dp_off_q <= {haddr_i[TMR_OFF_W-1:2], 2'b00};
   end

   assign wr_en    = dp_write_q && hready_i;
   assign count_wr = wr_en && (dp_off_q == TMR_COUNT);

   // Configuration registers
   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q     <= '0;
         prescale_q <= '0;
         compare_q  <= '0;
      end else if (wr_en) begin
         case (dp_off_q)
            TMR_CTRL:     ctrl_q     <= hwdata_i[1:0];
            TMR_PRESCALE: prescale_q <= hwdata_i;
            TMR_COMPARE:  compare_q  <= hwdata_i;
            default:      ;                       // COUNT and STATUS below
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Counting
   //////////////////////////////////////////////////////////////////////

   // One tick every prescale plus one cycles
   assign tick      = ctrl_q[TMR_CTRL_EN] && (pre_cnt_q == '0);
   assign count_inc = count_q + 1'b1;

   always_ff @(posedge hclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pre_cnt_q <= '0;
         count_q   <= '0;
         match_q   <= 1'b0;
         pending_q <= 1'b0;
         irq_o     <= 1'b0;
      end else begin
         if (!ctrl_q[TMR_CTRL_EN] || tick)
            pre_cnt_q <= prescale_q;              // Reload
         else
            pre_cnt_q <= pre_cnt_q - 1'b1;

         if (count_wr)
            count_q <= hwdata_i;                  // Bus write beats the tick
         else if (tick)
            count_q <= count_inc;

         match_q <= tick && !count_wr && (count_inc == compare_q);

         // A new match wins over a clear in the same cycle
         if (match_q)
            pending_q <= 1'b1;
         else if (wr_en && (dp_off_q == TMR_STATUS) && hwdata_i[TMR_STATUS_PEND])
            pending_q <= 1'b0;

         irq_o <= pending_q && ctrl_q[TMR_CTRL_IE];
      end
   end

   // Read mux, undefined offsets read zero
   always_comb begin
      case (dp_off_q)
         TMR_CTRL:     hrdata_o = {{(HDATA_W-2){1'b0}}, ctrl_q};
         TMR_PRESCALE: hrdata_o = prescale_q;
         TMR_COUNT:    hrdata_o = count_q;
         TMR_COMPARE:  hrdata_o = compare_q;
         TMR_STATUS:   hrdata_o = {{(HDATA_W-1){1'b0}}, pending_q};
         default:      hrdata_o = '0;
      endcase
   end

   assign hreadyout_o = 1'b1;                     // Zero wait states
   assign hresp_o     = 1'b0;

   // Interrupt only while pending and enabled except right after a bus write
   a_irq_cause: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
      irq_o |-> (pending_q && ctrl_q[TMR_CTRL_IE]) || $past(wr_en));

endmodule

`default_nettype wire

//--- src/ahb_periph_sys.sv
//////////////////////////////////////////////////////////////////////
// Peripheral system top with decoder, SRAM and timer on one bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ahb_periph_sys
   import ahb_periph_pkg::*;
#(
   parameter int MEM_DEPTH = 512                  // SRAM depth in words
) (
   input  wire                hclk_i,
   input  wire                rst_n_i,
   input  wire [HADDR_W-1:0]  haddr_i,            // Master port
   input  wire [1:0]          htrans_i,
   input  wire                hwrite_i,
   input  wire [2:0]          hsize_i,
   input  wire [HDATA_W-1:0]  hwdata_i,
   output wire [HDATA_W-1:0]  hrdata_o,
   output wire                hready_o,
   output wire                hresp_o,
   output wire                irq_o
);

   logic               hready;                    // Shared ready to master and slaves
   logic               hsel_sram;
   logic               hsel_timer;
   logic [HDATA_W-1:0] sram_hrdata;
   logic               sram_hreadyout;
   logic               sram_hresp;
   logic [HDATA_W-1:0] timer_hrdata;
   logic               timer_hreadyout;
   logic               timer_hresp;

   assign hready_o = hready;

   ahb_decoder i_ahb_decoder (
      .hclk_i            ( hclk_i          ),
      .rst_n_i           ( rst_n_i         ),
      .haddr_i           ( haddr_i         ),
      .htrans_i          ( htrans_i        ),
      .hready_o          ( hready          ),
      .hsel_sram_o       ( hsel_sram       ),
      .hsel_timer_o      ( hsel_timer      ),
      .sram_hrdata_i     ( sram_hrdata     ),
      .sram_hreadyout_i  ( sram_hreadyout  ),
      .sram_hresp_i      ( sram_hresp      ),
      .timer_hrdata_i    ( timer_hrdata    ),
      .timer_hreadyout_i ( timer_hreadyout ),
      .timer_hresp_i     ( timer_hresp     ),
      .hrdata_o          ( hrdata_o        ),
      .hresp_o           ( hresp_o         ) );

   ahb_sram #(
      .MEM_DEPTH   ( MEM_DEPTH      ) )       // Aliases through its region
   i_ahb_sram (
      .hclk_i      ( hclk_i         ),
      .rst_n_i     ( rst_n_i        ),
      .hsel_i      ( hsel_sram      ),
      .haddr_i     ( haddr_i        ),
      .htrans_i    ( htrans_i       ),
      .hwrite_i    ( hwrite_i       ),
      .hsize_i     ( hsize_i        ),
      .hwdata_i    ( hwdata_i       ),
      .hready_i    ( hready         ),
      .hrdata_o    ( sram_hrdata    ),
      .hreadyout_o ( sram_hreadyout ),
      .hresp_o     ( sram_hresp     ) );

   ahb_timer i_ahb_timer (
      .hclk_i      ( hclk_i          ),
      .rst_n_i     ( rst_n_i         ),
      .hsel_i      ( hsel_timer      ),
      .haddr_i     ( haddr_i         ),
      .htrans_i    ( htrans_i        ),
      .hwrite_i    ( hwrite_i        ),
      .hsize_i     ( hsize_i         ),
      .hwdata_i    ( hwdata_i        ),
      .hready_i    ( hready          ),
      .hrdata_o    ( timer_hrdata    ),
      .hreadyout_o ( timer_hreadyout ),
      .hresp_o     ( timer_hresp     ),
      .irq_o       ( irq_o           ) );   // Straight to the pin

endmodule

`default_nettype wire

//--- bench/tb_ahb_periph_sys.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the AHB-Lite peripheral system with master tasks,
// SRAM reference model and directed tests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_ahb_periph_sys
   import ahb_periph_pkg::*;
();

   localparam int MEM_DEPTH = 512;
   localparam int WAIT_MAX  = 16;                 // Cycles a transfer may stall
   localparam int IRQ_MAX   = 200;                // Cycles for the interrupt to show
   localparam int IRQ_N     = 10;                 // Compare value of the irq run
   localparam int PRE_P     = 3;                  // Prescale of the second run
   localparam int IDLE_M    = 40;                 // Idle cycles of the second run

   logic               hclk;
   logic               rst_n;
   logic [HADDR_W-1:0] haddr;
   logic [1:0]         htrans;
   logic               hwrite;
   logic [2:0]         hsize;
   logic [HDATA_W-1:0] hwdata;
   wire  [HDATA_W-1:0] hrdata;
   wire                hready;
   wire                hresp;
   wire                irq;

   int                 err_cnt;
   int                 tmo_cnt;
   integer             seed;

   // Pending transfers and the read data of the last run
   logic [HADDR_W-1:0] q_addr  [$];
   logic               q_write [$];
   logic [2:0]         q_size  [$];
   logic [HDATA_W-1:0] q_wdata [$];
   logic               q_err   [$];               // Unmapped, ERROR expected
   logic [HDATA_W-1:0] rd_data [$];

   logic [HDATA_W-1:0] model [MEM_DEPTH];         // SRAM reference

   ahb_periph_sys #(
      .MEM_DEPTH ( MEM_DEPTH ) )
   i_ahb_periph_sys (
      .hclk_i   ( hclk   ),
      .rst_n_i  ( rst_n  ),
      .haddr_i  ( haddr  ),
      .htrans_i ( htrans ),
      .hwrite_i ( hwrite ),
      .hsize_i  ( hsize  ),
      .hwdata_i ( hwdata ),
      .hrdata_o ( hrdata ),
      .hready_o ( hready ),
      .hresp_o  ( hresp  ),
      .irq_o    ( irq    ) );

   always #10 hclk = ~hclk;                       // 20 ns period

   task automatic check(input logic [HDATA_W-1:0] act_val, input logic [HDATA_W-1:0] exp_val,
                        input string msg);
      if (act_val !== exp_val) begin
         $display("ERR %0t ns: %s, got %08h expected %08h", $time, msg, act_val, exp_val);
         err_cnt++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   function automatic int word_idx(input logic [HADDR_W-1:0] addr);
      return int'((addr >> 2) % MEM_DEPTH);      // Aliases through the region
   endfunction

   task automatic model_write(input logic [HADDR_W-1:0] addr, input logic [2:0] size,
                              input logic [HDATA_W-1:0] data);
      logic [3:0] be;
      case (size)
         HSIZE_BYTE: be = 4'b0001 << addr[1:0];  // Little endian lanes
         HSIZE_HALF: be = addr[1] ? 4'b1100 : 4'b0011;
         default:    be = 4'b1111;
      endcase
      for (int b = 0; b < 4; b++) begin
         if (be[b])
            model[word_idx(addr)][8*b +: 8] = data[8*b +: 8];
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Master side
   //////////////////////////////////////////////////////////////////////

   task automatic add_xfer(input logic [HADDR_W-1:0] addr, input logic wr,
                           input logic [2:0] size, input logic [HDATA_W-1:0] data,
                           input logic err);
      q_addr.push_back(addr);
      q_write.push_back(wr);
      q_size.push_back(size);
      q_wdata.push_back(data);
      q_err.push_back(err);
   endtask

   // Runs the queued transfers back to back, address and data phases overlapped
   task automatic run_xfers();
      int   n;
      int   ap;                                   // Next address phase
      int   dp;                                   // Transfer in data phase
      int   waits;
      logic done;
      n = q_addr.size();
      ap = 0;
      dp = -1;
      waits = 0;
      done = 1'b0;
      rd_data.delete();
      while (!done) begin
         @(posedge hclk);
         #2;
         if (ap < n) begin
            haddr  = q_addr[ap];
            htrans = HTRANS_NONSEQ;
            hwrite = q_write[ap];
            hsize  = q_size[ap];
         end else begin
            htrans = HTRANS_IDLE;
            hwrite = 1'b0;
         end
         hwdata = (dp >= 0 && q_write[dp]) ? q_wdata[dp] : '0;
         @(negedge hclk);                          // Stable until the next edge
         if (dp >= 0 && q_err[dp]) begin
            check(hresp, 1'b1, "ERROR response");
            check(hready, waits != 0, "ready in ERROR sequence");
         end else begin
            check(hready, 1'b1, "ready during OKAY transfer");
            check(hresp, 1'b0, "OKAY response");
         end
         if (hready) begin
            if (dp >= 0)
               rd_data.push_back(hrdata);         // Data phase ends at this edge
            dp = (ap < n) ? ap : -1;
            if (ap < n)
               ap++;
            waits = 0;
            done = (dp < 0) && (ap >= n);
         end else begin
            waits++;
            if (waits > WAIT_MAX) begin
               $display("Timeout waiting for hready_o at %0t ns", $time);
               tmo_cnt++;
               done = 1'b1;
               @(posedge hclk);
               #2;
               htrans = HTRANS_IDLE;
            end
         end
      end
      q_addr.delete();
      q_write.delete();
      q_size.delete();
      q_wdata.delete();
      q_err.delete();
   endtask

   task automatic write_reg(input logic [HADDR_W-1:0] addr, input logic [HDATA_W-1:0] data);
      add_xfer(addr, 1'b1, HSIZE_WORD, data, 1'b0);
      run_xfers();
   endtask

   task automatic read_reg(input logic [HADDR_W-1:0] addr, output logic [HDATA_W-1:0] data);
      add_xfer(addr, 1'b0, HSIZE_WORD, '0, 1'b0);
      run_xfers();
      data = (rd_data.size() > 0) ? rd_data[0] : 'x;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge hclk);
         #2;
         htrans = HTRANS_IDLE;
      end
   endtask

   task automatic wait_irq(input logic level, input int limit, input string what);
      int cnt;
      cnt = 0;
      while (irq !== level && cnt < limit) begin
         @(negedge hclk);
         cnt++;
      end
      if (irq !== level) begin
         $display("Timeout waiting for %s at %0t ns", what, $time);
         tmo_cnt++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_sram_round_trip();
      logic [HADDR_W-1:0] addr [8];
      logic [HDATA_W-1:0] data;
      for (int k = 0; k < 8; k++) begin
         addr[k] = ({$random(seed)} % MEM_DEPTH) * 4;
         data = $random(seed);
         model_write(addr[k], HSIZE_WORD, data);
         add_xfer(addr[k], 1'b1, HSIZE_WORD, data, 1'b0);
      end
      run_xfers();                                // Pipelined writes
      for (int k = 0; k < 8; k++)
         add_xfer(addr[k], 1'b0, HSIZE_WORD, '0, 1'b0);
      run_xfers();
      for (int k = 0; k < 8; k++)
         check(rd_data[k], model[word_idx(addr[k])], "SRAM word read back");
   endtask

   task automatic test_narrow_writes();
      logic [HADDR_W-1:0] base;
      logic [HADDR_W-1:0] addr;
      logic [2:0]         size;
      logic [HDATA_W-1:0] data;
      base = ({$random(seed)} % MEM_DEPTH) * 4;
      data = $random(seed);
      model_write(base, HSIZE_WORD, data);
      add_xfer(base, 1'b1, HSIZE_WORD, data, 1'b0);
      for (int k = 0; k < 6; k++) begin
         size = (k % 2 == 0) ? HSIZE_BYTE : HSIZE_HALF;
         addr = base + ((size == HSIZE_BYTE) ? {$random(seed)} % 4 : ({$random(seed)} % 2) * 2);
         data = $random(seed);                    // Unused lanes carry noise
         model_write(addr, size, data);
         add_xfer(addr, 1'b1, size, data, 1'b0);
      end
      add_xfer(base, 1'b0, HSIZE_WORD, '0, 1'b0);
      add_xfer(base + MEM_DEPTH * 4, 1'b0, HSIZE_WORD, '0, 1'b0); // Aliased copy
      run_xfers();
      check(rd_data[7], model[word_idx(base)], "merged byte and halfword lanes");
      check(rd_data[8], model[word_idx(base)], "aliased SRAM read");
   endtask

   task automatic test_unmapped();
      add_xfer(32'h6000_0000, 1'b0, HSIZE_WORD, '0, 1'b1);
      run_xfers();                                // Two cycle ERROR
      add_xfer(32'h0000_0010, 1'b1, HSIZE_WORD, 32'hC0DE_5A5A, 1'b0);
      model_write(32'h0000_0010, HSIZE_WORD, 32'hC0DE_5A5A);
      add_xfer(32'h0000_0010, 1'b0, HSIZE_WORD, '0, 1'b0);
      run_xfers();
      check(rd_data[1], model[word_idx(32'h0000_0010)], "SRAM read after ERROR");
   endtask

   task automatic test_timer_regs();
      logic [HDATA_W-1:0] val;
      logic [HDATA_W-1:0] pat [3];
      check(irq, 1'b0, "irq_o after reset");
      for (int r = 0; r < 5; r++) begin
         read_reg(TIMER_BASE + 4 * r, val);
         check(val, '0, "timer reset value");
      end
      for (int r = 0; r < 3; r++) begin           // PRESCALE, COUNT, COMPARE
         pat[r] = $random(seed);
         write_reg(TIMER_BASE + 4 * (r + 1), pat[r]);
      end
      write_reg(TIMER_BASE + TMR_CTRL, 32'h0000_0002); // Interrupt enable only
      for (int r = 0; r < 3; r++) begin
         read_reg(TIMER_BASE + 4 * (r + 1), val);
         check(val, pat[r], "timer register read back");
      end
      read_reg(TIMER_BASE + TMR_CTRL, val);
      check(val, 32'h0000_0002, "CTRL read back");
      write_reg(TIMER_BASE + 32'h14, 32'hFFFF_FFFF);
      read_reg(TIMER_BASE + 32'h14, val);
      check(val, '0, "undefined timer offset");
      write_reg(TIMER_BASE + TMR_CTRL, '0);
   endtask

   task automatic test_timer_irq();
      logic [HDATA_W-1:0] val;
      int                 polls;
      int                 exp_cnt;
      write_reg(TIMER_BASE + TMR_PRESCALE, '0);
      write_reg(TIMER_BASE + TMR_COUNT, '0);
      write_reg(TIMER_BASE + TMR_COMPARE, IRQ_N);
      write_reg(TIMER_BASE + TMR_CTRL, 32'h0000_0003);
      wait_irq(1'b1, IRQ_MAX, "irq_o to rise");
      write_reg(TIMER_BASE + TMR_STATUS, 32'h0000_0001);
      wait_irq(1'b0, 4, "irq_o to fall after clear");

      // Match with the interrupt masked
      write_reg(TIMER_BASE + TMR_CTRL, 32'h0000_0001);
      write_reg(TIMER_BASE + TMR_COUNT, '0);
      val = '0;
      polls = 0;
      while (!val[TMR_STATUS_PEND] && polls < 50) begin
         read_reg(TIMER_BASE + TMR_STATUS, val);
         check(irq, 1'b0, "irq_o with interrupt disabled");
         polls++;
      end
      if (!val[TMR_STATUS_PEND]) begin
         $display("Timeout waiting for the match pending bit at %0t ns", $time);
         tmo_cnt++;
      end
      repeat (2) @(negedge hclk);                 // irq_o lags pending by one cycle
      check(irq, 1'b0, "irq_o with match pending and interrupt disabled");
      write_reg(TIMER_BASE + TMR_STATUS, 32'h0000_0001);

      // Prescaled counting
      write_reg(TIMER_BASE + TMR_CTRL, '0);
      write_reg(TIMER_BASE + TMR_PRESCALE, PRE_P);
      write_reg(TIMER_BASE + TMR_COUNT, '0);
      write_reg(TIMER_BASE + TMR_CTRL, 32'h0000_0001);
      idle_cycles(IDLE_M);
      read_reg(TIMER_BASE + TMR_COUNT, val);
      exp_cnt = IDLE_M / (PRE_P + 1);
      check((val + 1 >= exp_cnt) && (val <= exp_cnt + 1), 1'b1,
            $sformatf("prescaled count %0d not within one tick of %0d", val, exp_cnt));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      hclk    = 1'b0;
      rst_n   = 1'b0;
      haddr   = '0;
      htrans  = HTRANS_IDLE;
      hwrite  = 1'b0;
      hsize   = HSIZE_WORD;
      hwdata  = '0;
      err_cnt = 0;
      tmo_cnt = 0;
      seed    = 55621;
      repeat (4) @(posedge hclk);
      #2;
      rst_n = 1'b1;
      @(negedge hclk);
      check(hready, 1'b1, "hready_o after reset");
      check(hresp, 1'b0, "hresp_o after reset");
      test_sram_round_trip();
      test_narrow_writes();
      test_unmapped();
      test_timer_regs();                          // Before the timer is touched
      test_timer_irq();
      $display("Check errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
      if (err_cnt == 0 && tmo_cnt == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- ahb_periph_sys.f
src/ahb_periph_pkg.sv
src/ahb_decoder.sv
src/ahb_sram.sv
src/ahb_timer.sv
src/ahb_periph_sys.sv
bench/tb_ahb_periph_sys.sv

//--- Makefile
TOP = tb_ahb_periph_sys

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ahb_periph_sys.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing -Wall --top-module ahb_periph_sys -f ahb_periph_sys.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
